/* Makefile */
# Verilator build and run of the request crossbar testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass if the pass message is printed"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module xbar_tb -f filelist.f -o xbar_sim
	@out=$$(./obj_dir/xbar_sim); \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

/* filelist.f */
hw/xbar_cfg_pkg.sv
hw/xbar_req_pkg.sv
hw/sync_fifo.sv
hw/chan_ingress.sv
hw/rr_arbiter.sv
hw/wbuf_freelist.sv
hw/bank_port.sv
hw/xbar_top.sv
sim/xbar_tb.sv

/* hw/bank_port.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_port #(
  parameter int NUM_CH     = 3,
  parameter int WBUF_DEPTH = 32
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic [NUM_CH-1:0]                    head_valid_i,
  input  xbar_req_pkg::chan_req_t [NUM_CH-1:0] head_req_i,
  input  logic [NUM_CH-1:0]                    want_i,
  output logic [NUM_CH-1:0]                    grant_o,
  output logic                                 bank_valid_o,
  input  logic                                 bank_ready_i,
  output xbar_req_pkg::bank_req_t              bank_req_o,
  input  logic                                 free_valid_i,
  input  xbar_req_pkg::wbuf_id_t               free_id_i
);

  import xbar_cfg_pkg::*;
  import xbar_req_pkg::*;

  logic [NUM_CH-1:0] is_write;
  logic [NUM_CH-1:0] arb_req;
  logic [NUM_CH-1:0] arb_gnt;
  logic              id_avail;
  logic              xfer;
  logic              alloc;
  wbuf_id_t          head_id;
  chan_req_t         sel_req;
  logic [CH_W-1:0]   sel_ch;

  //------------------------------------------------------------
  // request vector, writes wait while no id is free
  //------------------------------------------------------------
  always_comb begin
    for (int c = 0; c < NUM_CH; c++) begin
      is_write[c] = (head_req_i[c].op == WRITE);
      arb_req[c]  = head_valid_i[c] & want_i[c] & (id_avail | ~is_write[c]);
    end
  end

  rr_arbiter #(
    .N (NUM_CH)
  ) u_arb (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (arb_req),
    .advance_i (xfer),
    .grant_o   (arb_gnt)
  );

  wbuf_freelist #(
    .WBUF_DEPTH (WBUF_DEPTH)
  ) u_freelist (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .alloc_i   (alloc),
    .avail_o   (id_avail),
    .head_id_o (head_id),
    .free_i    (free_valid_i),
    .free_id_i (free_id_i)
  );

  //------------------------------------------------------------
  // output mux
  //------------------------------------------------------------
  always_comb begin
    sel_req = '0;
    sel_ch  = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      if (arb_gnt[c]) begin
        sel_req = head_req_i[c];
        sel_ch  = CH_W'(c);
      end
    end
  end

  assign bank_valid_o = |arb_gnt;
  assign xfer         = bank_valid_o & bank_ready_i;
  assign alloc        = xfer & (sel_req.op == WRITE);
  assign grant_o      = {NUM_CH{xfer}} & arb_gnt;

  always_comb begin
    bank_req_o.ch_id   = sel_ch;
    bank_req_o.op      = sel_req.op;
    bank_req_o.addr    = sel_req.addr;
    bank_req_o.data    = sel_req.data;
    // reads and reserved ops carry no id
    bank_req_o.wbuf_id = (sel_req.op == WRITE) ? head_id : '0;
  end

  // a stalled request, id included, must not change under the bank
  assert property (@(posedge clk_i) disable iff (rst_i)
                   bank_valid_o && !bank_ready_i |=> bank_valid_o && $stable(bank_req_o))
    else $error("bank_port: request changed while stalled");

endmodule

`default_nettype wire

/* hw/chan_ingress.sv */
`timescale 1ns/1ps
`default_nettype none

module chan_ingress #(
  parameter int NUM_BANK      = 4,
  parameter int INGRESS_DEPTH = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  input  xbar_req_pkg::chan_req_t req_i,
  output logic                    head_valid_o,
  output xbar_req_pkg::chan_req_t head_req_o,
  output logic [NUM_BANK-1:0]     want_bank_o,
  input  logic [NUM_BANK-1:0]     grant_i
);

  import xbar_cfg_pkg::*;
  import xbar_req_pkg::*;

  logic fifo_full;
  logic fifo_empty;

  sync_fifo #(
    .T     (chan_req_t),
    .DEPTH (INGRESS_DEPTH)
  ) u_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (valid_i & ready_o),
    .data_i  (req_i),
    .pop_i   (|grant_i),
    .data_o  (head_req_o),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  assign ready_o      = !fifo_full;
  assign head_valid_o = !fifo_empty;

  // bank select from the low line address bits
  assign want_bank_o = head_valid_o ? (NUM_BANK'(1) << head_req_o.addr[BANK_W-1:0]) : '0;

  // only the bank the head points at may take it
  assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(grant_i))
    else $error("chan_ingress: head granted by more than one bank");

endmodule

`default_nettype wire

/* hw/rr_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
  parameter int N = 3
) (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic [N-1:0] req_i,
  input  logic         advance_i,
  output logic [N-1:0] grant_o
);

  localparam int IW = (N > 1) ? $clog2(N) : 1;

  logic [IW-1:0] ptr_q;
  logic [N-1:0]  lock_q;
  logic [N-1:0]  pick;
  logic [IW-1:0] gnt_idx;

  // first requester at or after ptr_q, lowest offset wins
  always_comb begin
    int idx;
    pick = '0;
    for (int i = N - 1; i >= 0; i--) begin
      idx = int'(ptr_q) + i;
      if (idx >= N) begin
        idx = idx - N;
      end
      if (req_i[idx]) begin
        pick = N'(1) << idx;
      end
    end
  end

  // a waiting grant is held until it transfers
  assign grant_o = (|(lock_q & req_i)) ? lock_q : pick;

  always_comb begin
    gnt_idx = '0;
    for (int i = 0; i < N; i++) begin
      if (grant_o[i]) begin
        gnt_idx = IW'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q  <= '0;
      lock_q <= '0;
    end else if (advance_i) begin
      ptr_q  <= (gnt_idx == IW'(N - 1)) ? '0 : gnt_idx + 1'b1;
      lock_q <= '0;
    end else begin
      lock_q <= grant_o;
    end
  end

endmodule

`default_nettype wire

/* hw/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic full_o,
  output logic empty_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;

  // wrap at DEPTH, not only at powers of two
  function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign data_o  = mem[rd_ptr_q];
  assign full_o  = (count_q == CW'(DEPTH));
  assign empty_o = (count_q == '0);

  assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_o)
    else $error("sync_fifo: push while full");
  assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o)
    else $error("sync_fifo: pop while empty");

endmodule

`default_nettype wire

/* hw/wbuf_freelist.sv */
`timescale 1ns/1ps
`default_nettype none

module wbuf_freelist #(
  parameter int WBUF_DEPTH = 32
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   alloc_i,
  output logic                   avail_o,
  output xbar_req_pkg::wbuf_id_t head_id_o,
  input  logic                   free_i,
  input  xbar_req_pkg::wbuf_id_t free_id_i
);

  import xbar_req_pkg::*;

  localparam int CW = $clog2(WBUF_DEPTH + 1);

  logic [CW-1:0] init_cnt_q;
  logic          init_busy;
  logic          fifo_push;
  logic          fifo_full;
  logic          fifo_empty;
  wbuf_id_t      fifo_wdata;

  //------------------------------------------------------------
  // fill with ids 0..WBUF_DEPTH-1 after reset
  //------------------------------------------------------------
  assign init_busy = (init_cnt_q != CW'(WBUF_DEPTH));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      init_cnt_q <= '0;
    end else if (init_busy) begin
      init_cnt_q <= init_cnt_q + 1'b1;
    end
  end

  assign fifo_push  = init_busy | free_i;
  assign fifo_wdata = init_busy ? wbuf_id_t'(init_cnt_q) : free_id_i;

  sync_fifo #(
    .T     (wbuf_id_t),
    .DEPTH (WBUF_DEPTH)
  ) u_ids (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (fifo_push),
    .data_i  (fifo_wdata),
    .pop_i   (alloc_i),
    .data_o  (head_id_o),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  assign avail_o = !fifo_empty && !init_busy;

  assert property (@(posedge clk_i) disable iff (rst_i) alloc_i |-> avail_o)
    else $error("wbuf_freelist: alloc with no id available");
  // a free must return an id that is out, so never during the fill
  assert property (@(posedge clk_i) disable iff (rst_i) free_i |-> !fifo_full && !init_busy)
    else $error("wbuf_freelist: free of an id that was never allocated");

endmodule

`default_nettype wire

/* hw/xbar_cfg_pkg.sv */
`default_nettype none

package xbar_cfg_pkg;

  // crossbar geometry
  localparam int NUM_CH   = 3;
  localparam int NUM_BANK = 4;
  localparam int BANK_W   = 2;
  localparam int CH_W     = 2;

  // address bits 31..4 of a cache line
  localparam int LINE_ADDR_W = 28;
  localparam int DATA_W      = 128;

  // write buffer ids, per bank
  localparam int WBUF_DEPTH = 32;
  localparam int WBUF_AW    = 5;

  // channel request buffering
  localparam int INGRESS_DEPTH = 2;

endpackage

`default_nettype wire

/* hw/xbar_req_pkg.sv */
`default_nettype none

package xbar_req_pkg;

  // 2 and 3 are reserved, pass through without an id
  typedef enum logic [1:0] {
    READ  = 2'd0,
    WRITE = 2'd1
  } opcode_e;

  typedef logic [xbar_cfg_pkg::WBUF_AW-1:0] wbuf_id_t;

  // as seen at a channel
  typedef struct packed {
    opcode_e                              op;
    logic [xbar_cfg_pkg::LINE_ADDR_W-1:0] addr;
    logic [xbar_cfg_pkg::DATA_W-1:0]      data;
  } chan_req_t;

  // as delivered to a bank
  typedef struct packed {
    logic [xbar_cfg_pkg::CH_W-1:0]        ch_id;
    opcode_e                              op;
    logic [xbar_cfg_pkg::LINE_ADDR_W-1:0] addr;
    logic [xbar_cfg_pkg::DATA_W-1:0]      data;
    wbuf_id_t                             wbuf_id;
  } bank_req_t;

endpackage

`default_nettype wire

/* hw/xbar_top.sv */
`timescale 1ns/1ps
`default_nettype none

module xbar_top #(
  parameter int NUM_CH        = xbar_cfg_pkg::NUM_CH,
  parameter int NUM_BANK      = xbar_cfg_pkg::NUM_BANK,
  parameter int INGRESS_DEPTH = xbar_cfg_pkg::INGRESS_DEPTH,
  parameter int WBUF_DEPTH    = xbar_cfg_pkg::WBUF_DEPTH
) (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  logic [NUM_CH-1:0]                      ch_valid_i,
  output logic [NUM_CH-1:0]                      ch_ready_o,
  input  xbar_req_pkg::chan_req_t [NUM_CH-1:0]   ch_req_i,
  output logic [NUM_BANK-1:0]                    bank_valid_o,
  input  logic [NUM_BANK-1:0]                    bank_ready_i,
  output xbar_req_pkg::bank_req_t [NUM_BANK-1:0] bank_req_o,
  input  logic [NUM_BANK-1:0]                    free_valid_i,
  input  xbar_req_pkg::wbuf_id_t [NUM_BANK-1:0]  free_id_i
);

  import xbar_req_pkg::*;

  logic [NUM_CH-1:0]                 head_valid;
  chan_req_t [NUM_CH-1:0]            head_req;
  logic [NUM_CH-1:0][NUM_BANK-1:0]   want_cb;
  logic [NUM_CH-1:0][NUM_BANK-1:0]   grant_cb;
  logic [NUM_BANK-1:0][NUM_CH-1:0]   want_bc;
  logic [NUM_BANK-1:0][NUM_CH-1:0]   grant_bc;

  //------------------------------------------------------------
  // channel side
  //------------------------------------------------------------
  for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
    chan_ingress #(
      .NUM_BANK      (NUM_BANK),
      .INGRESS_DEPTH (INGRESS_DEPTH)
    ) u_ingress (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .valid_i      (ch_valid_i[c]),
      .ready_o      (ch_ready_o[c]),
      .req_i        (ch_req_i[c]),
      .head_valid_o (head_valid[c]),
      .head_req_o   (head_req[c]),
      .want_bank_o  (want_cb[c]),
      .grant_i      (grant_cb[c])
    );
  end

  // want goes channel->bank, grant comes back bank->channel
  for (genvar c = 0; c < NUM_CH; c++) begin : g_xpose_ch
    for (genvar b = 0; b < NUM_BANK; b++) begin : g_xpose_bank
      assign want_bc[b][c]  = want_cb[c][b];
      assign grant_cb[c][b] = grant_bc[b][c];
    end
  end

  //------------------------------------------------------------
  // bank side
  //------------------------------------------------------------
  for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
    bank_port #(
      .NUM_CH     (NUM_CH),
      .WBUF_DEPTH (WBUF_DEPTH)
    ) u_bank (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .head_valid_i (head_valid),
      .head_req_i   (head_req),
      .want_i       (want_bc[b]),
      .grant_o      (grant_bc[b]),
      .bank_valid_o (bank_valid_o[b]),
      .bank_ready_i (bank_ready_i[b]),
      .bank_req_o   (bank_req_o[b]),
      .free_valid_i (free_valid_i[b]),
      .free_id_i    (free_id_i[b])
    );
  end

endmodule

`default_nettype wire

/* sim/xbar_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module xbar_tb;

  import xbar_cfg_pkg::*;
  import xbar_req_pkg::*;

  localparam int TIMEOUT_CYCLES = 3000;

  logic                     clk_i = 1'b0;
  logic                     rst_i = 1'b1;
  logic [NUM_CH-1:0]        ch_valid_i = '0;
  logic [NUM_CH-1:0]        ch_ready_o;
  chan_req_t [NUM_CH-1:0]   ch_req_i = '0;
  logic [NUM_BANK-1:0]      bank_valid_o;
  logic [NUM_BANK-1:0]      bank_ready_i = '1;
  bank_req_t [NUM_BANK-1:0] bank_req_o;
  logic [NUM_BANK-1:0]      free_valid_i = '0;
  wbuf_id_t [NUM_BANK-1:0]  free_id_i = '0;

  int          cycle_cnt = 0;
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          failed_tests = 0;
  logic [31:0] lcg_state = 32'd95;
  bank_req_t   got_q[$];
  int          got_bank_q[$];

  xbar_top #(
    .NUM_CH        (NUM_CH),
    .NUM_BANK      (NUM_BANK),
    .INGRESS_DEPTH (INGRESS_DEPTH),
    .WBUF_DEPTH    (WBUF_DEPTH)
  ) u_xbar_top (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ch_valid_i   (ch_valid_i),
    .ch_ready_o   (ch_ready_o),
    .ch_req_i     (ch_req_i),
    .bank_valid_o (bank_valid_o),
    .bank_ready_i (bank_ready_i),
    .bank_req_o   (bank_req_o),
    .free_valid_i (free_valid_i),
    .free_id_i    (free_id_i)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  // every bank transfer, in bank order within a cycle
  always @(posedge clk_i) begin
    if (!rst_i) begin
      for (int b = 0; b < NUM_BANK; b++) begin
        if (bank_valid_o[b] && bank_ready_i[b]) begin
          got_q.push_back(bank_req_o[b]);
          got_bank_q.push_back(b);
        end
      end
    end
  end

  //------------------------------------------------------------
  // stimulus and expected values
  //------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic chan_req_t make_req(input opcode_e op, input int bank);
    chan_req_t   r;
    logic [31:0] w;
    w = lcg_next();
    r.op = op;
    r.addr = {w[LINE_ADDR_W-BANK_W-1:0], BANK_W'(bank)};
    for (int i = 0; i < DATA_W / 32; i++) begin
      r.data[i*32 +: 32] = lcg_next();
    end
    return r;
  endfunction

  function automatic bank_req_t make_exp(input int ch, input chan_req_t r, input wbuf_id_t id);
    bank_req_t e;
    e.ch_id = CH_W'(ch);
    e.op = r.op;
    e.addr = r.addr;
    e.data = r.data;
    e.wbuf_id = id;
    return e;
  endfunction

  task automatic check_req(input string name, input bank_req_t got, input bank_req_t exp);
    if (got !== exp) begin
      $display("MISMATCH %0t ns %s: expected %h got %h", $time, name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic check_id(input string name, input wbuf_id_t got, input wbuf_id_t exp);
    if (got !== exp) begin
      $display("MISMATCH %0t ns %s: expected %0d got %0d", $time, name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %0t ns %s: expected %b got %b", $time, name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic push_req(input int ch, input chan_req_t req);
    @(negedge clk_i);
    ch_req_i[ch]   = req;
    ch_valid_i[ch] = 1'b1;
    #1;
    while (!ch_ready_o[ch]) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    ch_valid_i[ch] = 1'b0;
  endtask

  // next recorded transfer, which must be on the given bank
  task automatic take_xfer(input int bank, output bank_req_t got);
    int b;
    while (got_q.size() == 0) begin
      @(negedge clk_i);
    end
    got = got_q.pop_front();
    b = got_bank_q.pop_front();
    for (int i = 0; i < NUM_BANK; i++) begin
      check_bit($sformatf("bank_valid_o[%0d]", i), b == i, bank == i);
    end
  endtask

  task automatic expect_xfer(input int bank, input bank_req_t exp);
    bank_req_t got;
    take_xfer(bank, got);
    check_req($sformatf("bank_req_o[%0d]", bank), got, exp);
  endtask

  task automatic end_test(input string name, input int errs_before);
    check_bit("no unexpected transfers", got_q.size() == 0, 1'b1);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  //------------------------------------------------------------
  // tests
  //------------------------------------------------------------
  task automatic route_all();
    int        errs;
    chan_req_t r;
    errs = err_cnt;
    for (int c = 0; c < NUM_CH; c++) begin
      for (int b = 0; b < NUM_BANK; b++) begin
        r = make_req(READ, b);
        push_req(c, r);
        expect_xfer(b, make_exp(c, r, '0));
      end
    end
    end_test("routing", errs);
  endtask

  task automatic round_robin_order();
    int        errs;
    chan_req_t r [NUM_CH][2];
    errs = err_cnt;
    @(negedge clk_i);
    bank_ready_i[2] = 1'b0;
    for (int c = 0; c < NUM_CH; c++) begin
      for (int k = 0; k < 2; k++) begin
        r[c][k] = make_req(READ, 2);
        push_req(c, r[c][k]);
      end
    end
    #1;
    check_bit("bank_valid_o[2]", bank_valid_o[2], 1'b1);
    check_req("bank_req_o[2]", bank_req_o[2], make_exp(0, r[0][0], '0));
    @(negedge clk_i);
    bank_ready_i[2] = 1'b1;
    // channel order 0 1 2 then again
    for (int k = 0; k < 2; k++) begin
      for (int c = 0; c < NUM_CH; c++) begin
        expect_xfer(2, make_exp(c, r[c][k], '0));
      end
    end
    end_test("round robin", errs);
  endtask

  task automatic hold_under_backpressure();
    int        errs;
    chan_req_t r [INGRESS_DEPTH+1];
    errs = err_cnt;
    for (int i = 0; i <= INGRESS_DEPTH; i++) begin
      r[i] = make_req(READ, 0);
    end
    @(negedge clk_i);
    bank_ready_i[0] = 1'b0;
    for (int i = 0; i < INGRESS_DEPTH; i++) begin
      push_req(0, r[i]);
    end
    // one more waits at the channel
    @(negedge clk_i);
    ch_req_i[0]   = r[INGRESS_DEPTH];
    ch_valid_i[0] = 1'b1;
    repeat (4) begin
      #1;
      check_bit("ch_ready_o[0]", ch_ready_o[0], 1'b0);
      check_bit("bank_valid_o[0]", bank_valid_o[0], 1'b1);
      check_req("bank_req_o[0]", bank_req_o[0], make_exp(0, r[0], '0));
      @(negedge clk_i);
    end
    bank_ready_i[0] = 1'b1;
    push_req(0, r[INGRESS_DEPTH]);
    for (int i = 0; i <= INGRESS_DEPTH; i++) begin
      expect_xfer(0, make_exp(0, r[i], '0));
    end
    end_test("back-pressure", errs);
  endtask

  task automatic alloc_ids_in_order();
    int        errs;
    int        next_id;
    int        ch;
    opcode_e   op;
    wbuf_id_t  exp_id;
    chan_req_t r;
    bank_req_t got;
    errs = err_cnt;
    next_id = 0;
    for (int i = 0; i < 9; i++) begin
      op = (i % 3 == 2) ? READ : WRITE;
      ch = i % NUM_CH;
      r = make_req(op, 1);
      exp_id = (op == WRITE) ? wbuf_id_t'(next_id) : '0;
      push_req(ch, r);
      take_xfer(1, got);
      check_id("bank_req_o[1].wbuf_id", got.wbuf_id, exp_id);
      check_req("bank_req_o[1]", got, make_exp(ch, r, exp_id));
      if (op == WRITE) begin
        next_id++;
      end
    end
    end_test("id allocation", errs);
  endtask

  task automatic exhaust_and_free();
    int        errs;
    chan_req_t r;
    chan_req_t held;
    bank_req_t got;
    errs = err_cnt;
    for (int i = 0; i < WBUF_DEPTH; i++) begin
      r = make_req(WRITE, 3);
      push_req(0, r);
      take_xfer(3, got);
      check_id("bank_req_o[3].wbuf_id", got.wbuf_id, wbuf_id_t'(i));
      check_req("bank_req_o[3]", got, make_exp(0, r, wbuf_id_t'(i)));
    end
    // no id left, the read must overtake the write
    held = make_req(WRITE, 3);
    push_req(0, held);
    r = make_req(READ, 3);
    push_req(1, r);
    expect_xfer(3, make_exp(1, r, '0));
    @(negedge clk_i);
    #1;
    check_bit("bank_valid_o[3] with no free id", bank_valid_o[3], 1'b0);
    @(negedge clk_i);
    free_valid_i[3] = 1'b1;
    free_id_i[3]    = wbuf_id_t'(7);
    @(negedge clk_i);
    free_valid_i[3] = 1'b0;
    take_xfer(3, got);
    check_id("bank_req_o[3].wbuf_id", got.wbuf_id, wbuf_id_t'(7));
    check_req("bank_req_o[3]", got, make_exp(0, held, wbuf_id_t'(7)));
    end_test("exhaustion and free", errs);
  endtask

  task automatic banks_in_parallel();
    int        errs;
    chan_req_t r [NUM_CH];
    errs = err_cnt;
    r[0] = make_req(WRITE, 0);
    r[1] = make_req(opcode_e'(2'd3), 1);
    r[2] = make_req(READ, 2);
    @(negedge clk_i);
    bank_ready_i = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      ch_req_i[c]   = r[c];
      ch_valid_i[c] = 1'b1;
    end
    #1;
    for (int c = 0; c < NUM_CH; c++) begin
      check_bit($sformatf("ch_ready_o[%0d]", c), ch_ready_o[c], 1'b1);
    end
    @(negedge clk_i);
    ch_valid_i = '0;
    #1;
    while (!bank_valid_o[0]) begin
      @(negedge clk_i);
      #1;
    end
    for (int c = 0; c < NUM_CH; c++) begin
      check_bit($sformatf("bank_valid_o[%0d]", c), bank_valid_o[c], 1'b1);
    end
    @(negedge clk_i);
    bank_ready_i = '1;
    // reserved op passes through without an id
    for (int c = 0; c < NUM_CH; c++) begin
      expect_xfer(c, make_exp(c, r[c], '0));
    end
    end_test("bank independence", errs);
  endtask

  initial begin
    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;
    route_all();
    round_robin_order();
    hold_under_backpressure();
    alloc_ids_in_order();
    exhaust_and_free();
    banks_in_parallel();
    $display("%0d tests, %0d failed, %0d errors", test_cnt, failed_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
